// ==== matrix_fetch_pkg.sv ====
`default_nettype none

package matrix_fetch_pkg;

    // Element and bus widths
    localparam int WORD_W   = 16;
    localparam int INDEX_W  = 16;               // One coordinate half
    localparam int COORD_W  = 2 * INDEX_W;
    localparam int RESULT_W = 3 * WORD_W;

    typedef logic [WORD_W-1:0]   word_t;        // One matrix element
    typedef logic [INDEX_W-1:0]  index_t;       // Row or column index
    typedef logic [COORD_W-1:0]  coord_t;       // Row in 31:16, column in 15:0
    typedef logic [RESULT_W-1:0] result_t;

    // Bit 0 selects a three element fetch, bit 1 picks the column direction
    typedef enum logic [1:0] {
        MODE_SINGLE = 2'b00,
        MODE_ROW    = 2'b01,
        MODE_COL    = 2'b11
    } fetch_mode_t;

    // One queued command, 34 bits
    typedef struct packed {
        coord_t      base;
        fetch_mode_t mode;
    } fetch_req_t;

endpackage

`default_nettype wire

// ==== mem_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Read port of the matrix memory, data follows rd_en by one cycle
interface mem_rd_if import matrix_fetch_pkg::*; ();

    logic   rd_en;
    coord_t rd_addr;
    word_t  rd_data;
    logic   rd_valid;

    modport master (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    modport slave (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

`default_nettype wire

// ==== req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_fifo import matrix_fetch_pkg::*; #(
    parameter int REQ_DEPTH = 4
) (
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       push,
    input  fetch_req_t push_req,
    input  logic       pop,
    output fetch_req_t head,
    output logic       empty,
    output logic       credit_return
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    fetch_req_t       entries [REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign empty         = (count == '0);
    assign do_pop        = pop && !empty;
    assign credit_return = do_pop;      // Credit leaves in the pop cycle
    assign head          = entries[rd_ptr];

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or push with pop
            endcase
        end
    end

    // Storage, credits keep it from overflowing
    always_ff @(posedge CLK) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

endmodule

`default_nettype wire

// ==== matrix_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_fetch import matrix_fetch_pkg::*; (
    input  logic       CLK,
    input  logic       rst_n,
    input  fetch_req_t fifo_req,
    input  logic       fifo_empty,
    output logic       fifo_pop,
    mem_rd_if.master   rd,
    output logic       rsp_valid,
    output result_t    rsp_data
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,      // One read per cycle
        WAIT,       // Single word still in flight
        COLLECT,    // Tail of a three word burst
        DONE
    } state_t;

    state_t     state;
    state_t     next_state;
    fetch_req_t cmd_q;
    logic [1:0] issue_cnt;      // Reads sent so far
    logic [1:0] data_cnt;       // Words returned so far
    logic [1:0] last_slot;
    logic       is_single;
    index_t     base_row;
    index_t     base_col;
    index_t     step;
    result_t    result_q;

    assign is_single = (cmd_q.mode == MODE_SINGLE);
    assign last_slot = is_single ? 2'd0 : 2'd2;
    assign base_row  = cmd_q.base[COORD_W-1:INDEX_W];
    assign base_col  = cmd_q.base[INDEX_W-1:0];
    assign step      = index_t'(issue_cnt);

    assign fifo_pop  = (state == IDLE) && !fifo_empty;

    // Read address steps along the row or down the column, 16-bit wrap
    assign rd.rd_en = (state == ISSUE);
    always_comb begin
        case (cmd_q.mode)
            MODE_ROW: rd.rd_addr = {base_row, base_col + step};
            MODE_COL: rd.rd_addr = {base_row + step, base_col};
            default:  rd.rd_addr = cmd_q.base;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (!fifo_empty) next_state = ISSUE;
            end
            ISSUE: begin
                if (issue_cnt == last_slot) begin
                    next_state = is_single ? WAIT : COLLECT;
                end
            end
            WAIT, COLLECT: begin
                if (rd.rd_valid && data_cnt == last_slot) next_state = DONE;
            end
            DONE:    next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= IDLE;
            issue_cnt <= '0;
            data_cnt  <= '0;
        end else begin
            state <= next_state;
            if (fifo_pop) begin
                issue_cnt <= '0;
                data_cnt  <= '0;
            end else begin
                if (state == ISSUE && issue_cnt != last_slot) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (rd.rd_valid) data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    // Command and result payload
    always_ff @(posedge CLK) begin
        if (fifo_pop) cmd_q <= fifo_req;
        if (rd.rd_valid) begin
            result_q[data_cnt * WORD_W +: WORD_W] <= rd.rd_data;  // By arrival order
        end
    end

    assign rsp_valid = (state == DONE);
    assign rsp_data  = is_single ?
                       {{(RESULT_W - WORD_W){result_q[WORD_W-1]}}, result_q[WORD_W-1:0]} :
                       result_q;

endmodule

`default_nettype wire

// ==== matrix_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_mem import matrix_fetch_pkg::*; #(
    parameter int ROW_BITS = 4,
    parameter int COL_BITS = 4
) (
    input  logic    CLK,
    input  logic    wr_en,
    input  coord_t  wr_addr,
    input  word_t   wr_data,
    mem_rd_if.slave rd
);

    localparam int IDX_W   = ROW_BITS + COL_BITS;
    localparam int ENTRIES = 2 ** IDX_W;

    word_t            mem [ENTRIES];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;

    // Low bits of each half, so coordinates wrap at the matrix edge
    assign wr_idx = {wr_addr[INDEX_W +: ROW_BITS], wr_addr[0 +: COL_BITS]};
    assign rd_idx = {rd.rd_addr[INDEX_W +: ROW_BITS], rd.rd_addr[0 +: COL_BITS]};

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Registered read, valid one cycle after the request
    always_ff @(posedge CLK) begin
        rd.rd_valid <= rd.rd_en;
        if (rd.rd_en) begin
            rd.rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

// ==== matrix_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_fetch_top import matrix_fetch_pkg::*; #(
    parameter int ROW_BITS  = 4,
    parameter int COL_BITS  = 4,
    parameter int REQ_DEPTH = 4
) (
    input  logic        CLK,
    input  logic        rst_n,
    // Request side, credit based
    input  logic        req_valid,
    input  coord_t      req_base,
    input  fetch_mode_t req_mode,
    output logic        credit_return,
    // Matrix load port
    input  logic        wr_en,
    input  coord_t      wr_addr,
    input  word_t       wr_data,
    // Responses, always accepted
    output logic        rsp_valid,
    output result_t     rsp_data
);

    fetch_req_t push_req;
    fetch_req_t fifo_req;
    logic       fifo_empty;
    logic       fifo_pop;

    mem_rd_if rd_bus ();

    assign push_req = '{base: req_base, mode: req_mode};

    req_fifo #(
        .REQ_DEPTH(REQ_DEPTH)
    ) u_req_fifo (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .push         (req_valid),
        .push_req     (push_req),
        .pop          (fifo_pop),
        .head         (fifo_req),
        .empty        (fifo_empty),
        .credit_return(credit_return)
    );

    matrix_fetch u_matrix_fetch (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .fifo_req  (fifo_req),
        .fifo_empty(fifo_empty),
        .fifo_pop  (fifo_pop),
        .rd        (rd_bus.master),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    matrix_mem #(
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS)
    ) u_matrix_mem (
        .CLK    (CLK),
        .wr_en  (wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd     (rd_bus.slave)
    );

endmodule

`default_nettype wire

// ==== tb_matrix_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_fetch import matrix_fetch_pkg::*; ();

    localparam int ROW_BITS  = 4;
    localparam int COL_BITS  = 4;
    localparam int REQ_DEPTH = 4;
    localparam int NUM_ROWS  = 2 ** ROW_BITS;
    localparam int NUM_COLS  = 2 ** COL_BITS;
    localparam int MEM_IW    = ROW_BITS + COL_BITS;
    localparam int TIMEOUT   = 200;        // Cycles per wait
    localparam int NUM_STIM  = 15;
    localparam int STIM_IW   = $clog2(NUM_STIM);

    typedef struct packed {
        coord_t      base;
        fetch_mode_t mode;
        logic        b2b;                  // Send without draining first
    } stim_t;

    logic        CLK;
    logic        rst_n;
    logic        req_valid;
    coord_t      req_base;
    fetch_mode_t req_mode;
    logic        credit_return;
    logic        wr_en;
    coord_t      wr_addr;
    word_t       wr_data;
    logic        rsp_valid;
    result_t     rsp_data;

    word_t   mirror [2 ** MEM_IW];         // Copy of the matrix contents
    result_t exp_q [$];
    int      lat_q [$];                    // Cycles from req_valid, -1 when not timed
    int      req_cyc_q [$];                // Cycle of each req_valid pulse
    integer  seed;
    int      sent_cnt    = 0;
    int      credit_cnt  = 0;
    int      rsp_cnt     = 0;
    int      cyc         = 0;
    int      err_cnt     = 0;
    int      check_cnt   = 0;
    int      timeout_cnt = 0;
    logic    end_check;
    result_t exp_data;
    int      exp_lat;
    int      req_cyc;

    // Row 0x12 and column 0xFFFF lie past the edge and wrap
    stim_t stim_tbl [NUM_STIM] = '{
        '{32'h0002_0003, MODE_SINGLE, 1'b0},   // Positive element
        '{32'h0005_0006, MODE_SINGLE, 1'b0},   // Negative element
        '{32'h0001_0004, MODE_ROW,    1'b0},
        '{32'h0007_0002, MODE_COL,    1'b0},
        '{32'h0003_000F, MODE_ROW,    1'b0},   // Last column
        '{32'h000F_0009, MODE_COL,    1'b0},   // Last row
        '{32'h0012_FFFF, MODE_ROW,    1'b0},
        '{32'h0008_000A, MODE_SINGLE, 1'b0},
        '{32'h0000_0000, MODE_ROW,    1'b0},
        '{32'h0004_0004, MODE_COL,    1'b1},
        '{32'h000E_000E, MODE_SINGLE, 1'b1},
        '{32'h0009_000F, MODE_ROW,    1'b1},
        '{32'h000F_000F, MODE_COL,    1'b1},
        '{32'h0006_0001, MODE_SINGLE, 1'b1},
        '{32'h000A_0003, MODE_ROW,    1'b1}
    };

    matrix_fetch_top #(
        .ROW_BITS (ROW_BITS),
        .COL_BITS (COL_BITS),
        .REQ_DEPTH(REQ_DEPTH)
    ) dut0 (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_base     (req_base),
        .req_mode     (req_mode),
        .credit_return(credit_return),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // Element at a coordinate with each half wrapped to 16 bits and then to the matrix size
    function automatic word_t elem(input int row, input int col);
        int r;
        int c;
        r = (row & 32'hFFFF) % NUM_ROWS;
        c = (col & 32'hFFFF) % NUM_COLS;
        return mirror[MEM_IW'(r * NUM_COLS + c)];
    endfunction

    function automatic result_t expect_result(input coord_t base, input fetch_mode_t mode);
        int    row;
        int    col;
        word_t w;
        row = int'(base[31:16]);
        col = int'(base[15:0]);
        w   = elem(row, col);
        case (mode)
            MODE_ROW: return {elem(row, col + 2), elem(row, col + 1), w};
            MODE_COL: return {elem(row + 2, col), elem(row + 1, col), w};
            default:  return {{32{w[15]}}, w};   // Sign-extended single
        endcase
    endfunction

    task automatic write_word(input int row, input int col, input word_t data);
        @(posedge CLK);
        wr_en   <= 1'b1;
        wr_addr <= {16'(row), 16'(col)};
        wr_data <= data;
        mirror[MEM_IW'((row % NUM_ROWS) * NUM_COLS + col % NUM_COLS)] = data;
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        check_cnt++;
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        check_cnt++;
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
            err_cnt++;
        end
    endtask

    // Waits for a free credit, then drives one command for one cycle
    task automatic send_cmd(input coord_t base, input fetch_mode_t mode, input logic timed);
        int waited;
        waited = 0;
        @(posedge CLK);
        while ((sent_cnt - credit_cnt >= REQ_DEPTH) && (waited < TIMEOUT)) begin
            req_valid <= 1'b0;
            @(posedge CLK);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            $display("Timed out waiting for a request credit");
            timeout_cnt++;
        end else begin
            req_valid <= 1'b1;
            req_base  <= base;
            req_mode  <= mode;
            sent_cnt++;
            exp_q.push_back(expect_result(base, mode));
            // An idle unit pops one cycle after req_valid
            if (timed) begin
                lat_q.push_back((mode == MODE_SINGLE) ? 4 : 6);
            end else begin
                lat_q.push_back(-1);        // Depends on queue occupancy
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge CLK);
        req_valid <= 1'b0;
        while ((rsp_cnt != sent_cnt) && (waited < TIMEOUT)) begin
            @(posedge CLK);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            $display("Timed out waiting for all responses to come back");
            timeout_cnt++;
        end
    endtask

    // Request, response and credit monitor
    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (req_valid === 1'b1) begin
            req_cyc_q.push_back(cyc);
        end
        if (credit_return === 1'b1) begin
            credit_cnt <= credit_cnt + 1;
        end
        if (rsp_valid === 1'b1) begin
            rsp_cnt <= rsp_cnt + 1;
            if ((exp_q.size() == 0) || (req_cyc_q.size() == 0)) begin
                $display("A response arrived with no command outstanding");
                err_cnt++;
            end else begin
                exp_data = exp_q.pop_front();
                exp_lat  = lat_q.pop_front();
                req_cyc  = req_cyc_q.pop_front();
                check_result("rsp_data", exp_data, rsp_data);
                if (exp_lat >= 0) begin
                    check_count("rsp_valid cycles after req_valid", exp_lat, cyc - req_cyc);
                end
            end
        end
        if (end_check) begin
            check_count("credit_return pulses", sent_cnt, credit_cnt);
            check_count("rsp_valid pulses", sent_cnt, rsp_cnt);
        end
    end

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_base  = '0;
        req_mode  = MODE_SINGLE;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        end_check = 1'b0;
        seed      = 58;
        repeat (8) @(posedge CLK);
        rst_n <= 1'b1;

        // Load the whole matrix, then pin one positive and one negative element
        for (int i = 0; i < NUM_ROWS * NUM_COLS; i++) begin
            write_word(i / NUM_COLS, i % NUM_COLS, word_t'($random(seed)));
        end
        write_word(32'h12, 3, 16'h7ABC);   // Row 0x12 lands on row 2
        write_word(5, 6, 16'h8123);
        @(posedge CLK);
        wr_en <= 1'b0;

        for (int i = 0; i < NUM_STIM; i++) begin
            if (!stim_tbl[STIM_IW'(i)].b2b) begin
                drain();
            end
            send_cmd(stim_tbl[STIM_IW'(i)].base, stim_tbl[STIM_IW'(i)].mode,
                     !stim_tbl[STIM_IW'(i)].b2b);
        end
        drain();

        end_check <= 1'b1;
        @(posedge CLK);
        end_check <= 1'b0;
        @(posedge CLK);

        $display("Checks: %0d  errors: %0d  timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0)) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
matrix_fetch_pkg.sv
mem_rd_if.sv
req_fifo.sv
matrix_fetch.sv
matrix_mem.sv
matrix_fetch_top.sv
tb_matrix_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the matrix fetch testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_matrix_fetch -o sim_matrix_fetch \
    && ./obj_dir/sim_matrix_fetch > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "^Test passed$" sim.log && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
